// File: common/gfx_mapper_table.svh
`ifndef GFX_MAPPER_TABLE_SVH
`define GFX_MAPPER_TABLE_SVH

// Case items for the per-game bank table
// Expects bank_a, bank_b, set_used and req in scope
// Banks are one-hot, all zeros means nothing mapped

GAME_FFIGHT: begin
    bank_b   = 4'b0000;  // Single set only
    set_used = 1'b0;
    case (req.layer)
        OBJ, SCR1:  bank_a = 4'b0001;
        SCR2, SCR3: bank_a = 4'b0010;
        default:    bank_a = 4'b0000;  // Star field not on this board
    endcase
end

GAME_SF2: begin
    bank_b   = 4'b0010;  // Upper sprite codes
    // Sprites split by code range across two banks
    set_used = (req.layer == OBJ) && (req.code[15:14] != 2'd0);
    case (req.layer)
        OBJ:     bank_a = 4'b0001;
        SCR1:    bank_a = 4'b0010;
        SCR2:    bank_a = 4'b0100;
        SCR3:    bank_a = 4'b1000;
        default: bank_a = 4'b0000;
    endcase
end

`endif

// File: common/cps_gfx_pkg.sv
package cps_gfx_pkg;

    // Width of the ROM tile index, above the sub-tile row bits
    localparam int TILE_W = 20;

    // Graphics layers, same order as the board's layer select lines
    typedef enum logic [2:0] {
        OBJ   = 3'd0,
        SCR1  = 3'd1,
        SCR2  = 3'd2,
        SCR3  = 3'd3,
        STARS = 3'd4
    } layer_e;

    // Game ids, only a few carry their own table entry
    typedef enum logic [5:0] {
        GAME_1941     = 6'd0,
        GAME_CAPTCOMM = 6'd2,
        GAME_DINO     = 6'd5,
        GAME_FFIGHT   = 6'd7,
        GAME_GHOULS   = 6'd10,
        GAME_SF2      = 6'd25,
        GAME_STRIDER  = 6'd29
    } game_e;

    // One tile request from a layer fetcher
    typedef struct packed {
        layer_e      layer;
        logic [15:0] code;   // Tile code
    } gfx_req_t;

    // Bank config words as the CPU sees them
    // Nibble n of each word belongs to bank n
    typedef struct packed {
        logic [15:0] offset;
        logic [15:0] mask;
    } bank_cfg_t;

    // Mapper answer for one request
    typedef struct packed {
        logic [3:0] offset;
        logic [3:0] mask;
        logic       unmapped;  // No bank hit
    } map_res_t;

endpackage

// File: gfx/cps_bank_regs.sv
`timescale 1ns/1ps

module cps_bank_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr,    // CPU write strobe
    input  logic                   sel,   // 0 offset, 1 mask
    input  logic [15:0]            data,
    output cps_gfx_pkg::bank_cfg_t bank_cfg
);
    import cps_gfx_pkg::*;

    bank_cfg_t cfg_q;

    // Mask defaults to all ones so codes pass through unchanged
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg_q.offset <= 16'h0000;
            cfg_q.mask   <= 16'hFFFF;
        end else if (wr) begin
            if (sel) begin
                cfg_q.mask <= data;
            end else begin
                cfg_q.offset <= data;
            end
        end
    end

    assign bank_cfg = cfg_q;  // Seen by the mapper next cycle

    // A write with an unknown select would corrupt one word silently
    a_sel_known: assert property (
        @(posedge clk) disable iff (rst)
        wr |-> !$isunknown(sel)
    ) else $error("bank register write with unknown sel");

endmodule

// File: gfx/gfx_mappers.sv
`timescale 1ns/1ps

module gfx_mappers (
    input  logic                   clk,
    input  logic                   rst,
    input  cps_gfx_pkg::game_e     game,      // Static per game
    input  cps_gfx_pkg::bank_cfg_t bank_cfg,
    input  cps_gfx_pkg::gfx_req_t  req,
    output cps_gfx_pkg::map_res_t  map_res
);
    import cps_gfx_pkg::*;

    logic [3:0] bank_a;    // First set
    logic [3:0] bank_b;    // Second set, code range dependent
    logic       set_used;
    logic [3:0] eff_bank;
    map_res_t   res_q;

    // Table lookup straight from the request
    always_comb begin
        case (game)
            `include "gfx_mapper_table.svh"
            default: begin
                // Plain boards, everything in bank 0
                bank_a   = 4'b0001;
                bank_b   = 4'b0000;
                set_used = 1'b0;
            end
        endcase
    end

    assign eff_bank = set_used ? bank_b : bank_a;

    // Nibble pick, registered
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            res_q.offset   <= 4'h0;
            res_q.mask     <= 4'hF;
            res_q.unmapped <= 1'b1;
        end else begin
            res_q.unmapped <= (eff_bank == 4'b0000);
            case (eff_bank)
                4'b0001: begin
                    res_q.offset <= bank_cfg.offset[3:0];
                    res_q.mask   <= bank_cfg.mask[3:0];
                end
                4'b0010: begin
                    res_q.offset <= bank_cfg.offset[7:4];
                    res_q.mask   <= bank_cfg.mask[7:4];
                end
                4'b0100: begin
                    res_q.offset <= bank_cfg.offset[11:8];
                    res_q.mask   <= bank_cfg.mask[11:8];
                end
                4'b1000: begin
                    res_q.offset <= bank_cfg.offset[15:12];
                    res_q.mask   <= bank_cfg.mask[15:12];
                end
                default: begin
                    res_q.offset <= 4'h0;  // Unmapped, code passes as is
                    res_q.mask   <= 4'hF;
                end
            endcase
        end
    end

    assign map_res = res_q;

    // Table entries must never select two banks at once
    a_bank_onehot0: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(eff_bank)
    ) else $error("mapper selected more than one bank: %b", eff_bank);

endmodule

// File: gfx/gfx_addr_gen.sv
`timescale 1ns/1ps

module gfx_addr_gen #(
    parameter int SUB_W = 4  // Sub-tile row bits
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                req_valid,
    input  cps_gfx_pkg::gfx_req_t               req,
    input  logic [SUB_W-1:0]                    req_sub,
    input  cps_gfx_pkg::map_res_t               map_res,   // One cycle behind req
    output logic                                rom_valid,
    output logic [cps_gfx_pkg::TILE_W+SUB_W-1:0] rom_addr,
    output logic                                rom_unmapped
);
    import cps_gfx_pkg::*;

    // Code covers 16 bits of the tile index, rest is zero
    localparam int PAD_W = TILE_W - 16;

    logic             s1_valid;
    logic [15:0]      s1_code;
    logic [SUB_W-1:0] s1_sub;
    logic [3:0]       tile_hi;
    logic [TILE_W-1:0] tile;

    // Stage one, lines up with the mapper register
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            s1_code <= req.code;
            s1_sub  <= req_sub;
        end
    end

    // Bank nibble replaces the top of the code
    assign tile_hi = (s1_code[15:12] & map_res.mask) | map_res.offset;
    assign tile    = {{PAD_W{1'b0}}, tile_hi, s1_code[11:0]};

    // Stage two, ROM side
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_valid    <= 1'b0;
            rom_addr     <= '0;
            rom_unmapped <= 1'b1;
        end else begin
            rom_valid <= s1_valid;
            if (s1_valid) begin
                rom_addr     <= {tile, s1_sub};
                rom_unmapped <= map_res.unmapped;
            end
        end
    end

    // Fixed two cycle latency, no drops and no extra pulses
    a_latency: assert property (
        @(posedge clk) disable iff (rst)
        rom_valid == $past(req_valid, 2)
    ) else $error("rom_valid does not follow req_valid by two cycles");

endmodule

// File: hdl/gfx_rom_path.sv
`timescale 1ns/1ps

module gfx_rom_path #(
    parameter int SUB_W = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  cps_gfx_pkg::game_e                   game,
    // CPU side
    input  logic                                 cfg_wr,
    input  logic                                 cfg_sel,   // 0 offset, 1 mask
    input  logic [15:0]                          cfg_data,
    // Layer fetcher side
    input  logic                                 req_valid,
    input  cps_gfx_pkg::gfx_req_t                req,
    input  logic [SUB_W-1:0]                     req_sub,
    // ROM side
    output logic                                 rom_valid,
    output logic [cps_gfx_pkg::TILE_W+SUB_W-1:0] rom_addr,
    output logic                                 rom_unmapped
);
    import cps_gfx_pkg::*;

    bank_cfg_t bank_cfg;
    map_res_t  map_res;

    cps_bank_regs bank_regs_i (
        .clk      (clk),
        .rst      (rst),
        .wr       (cfg_wr),
        .sel      (cfg_sel),
        .data     (cfg_data),
        .bank_cfg (bank_cfg)
    );

    // Same request feeds both blocks
    gfx_mappers mappers_i (
        .clk      (clk),
        .rst      (rst),
        .game     (game),
        .bank_cfg (bank_cfg),
        .req      (req),
        .map_res  (map_res)
    );

    gfx_addr_gen #(
        .SUB_W (SUB_W)
    ) addr_gen_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .req_sub      (req_sub),
        .map_res      (map_res),
        .rom_valid    (rom_valid),
        .rom_addr     (rom_addr),
        .rom_unmapped (rom_unmapped)
    );

endmodule

// File: sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held for a fixed count of rising edges
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;  // Release off the edge, like the other inputs
    end

endmodule

// File: sim/gfx_rom_path_tb.sv
`timescale 1ns/1ps

module gfx_rom_path_tb;
    import cps_gfx_pkg::*;

    localparam int SUB_W      = 4;
    localparam int CLK_PERIOD = 8;
    localparam int N_DEFAULT  = 200;
    localparam int N_FFIGHT   = 150;
    localparam int N_SF2      = 150;
    localparam int N_REWRITE  = 250;
    localparam int TOTAL_REQ  = 1 + N_DEFAULT + N_FFIGHT + N_SF2 + N_REWRITE;

    typedef logic [TILE_W+SUB_W-1:0] addr_t;

    logic             clk;
    logic             rst;
    game_e            game;
    logic             cfg_wr;
    logic             cfg_sel;
    logic [15:0]      cfg_data;
    logic             req_valid;
    gfx_req_t         req;
    logic [SUB_W-1:0] req_sub;
    logic             rom_valid;
    addr_t            rom_addr;
    logic             rom_unmapped;

    logic [15:0] m_offset = 16'h0000;  // Model of the bank registers
    logic [15:0] m_mask   = 16'hFFFF;
    addr_t       exp_addr_q[$];         // Expected results in request order
    logic        exp_unm_q[$];
    int          bank_hits[5];          // Index 4 counts unmapped requests
    int          obj_split[2];          // SF2 sprite hits on bank 0 and bank 1
    int          test_checks, test_errors, total_checks, total_errors, n_tests;

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(16)) clkgen_i (.clk(clk), .rst(rst));

    gfx_rom_path #(.SUB_W(SUB_W)) gfx_rom_path_i (
        .clk(clk), .rst(rst), .game(game),
        .cfg_wr(cfg_wr), .cfg_sel(cfg_sel), .cfg_data(cfg_data),
        .req_valid(req_valid), .req(req), .req_sub(req_sub),
        .rom_valid(rom_valid), .rom_addr(rom_addr), .rom_unmapped(rom_unmapped)
    );

    task automatic check_addr(input addr_t got, input addr_t exp, input string name);
        test_checks++;
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        test_checks++;
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %b, expected %b", $time, name, got, exp);
            test_errors++;
        end
    endtask

    // Bank number from the game table or -1 when nothing is mapped
    function automatic int table_bank(input game_e g, input gfx_req_t r);
        if (g == GAME_FFIGHT) begin
            if (r.layer == OBJ || r.layer == SCR1) return 0;
            if (r.layer == SCR2 || r.layer == SCR3) return 1;
            return -1;                     // No star field
        end else if (g == GAME_SF2) begin
            if (r.layer == OBJ) return (r.code[15:14] == 2'd0) ? 0 : 1;
            if (r.layer == STARS) return -1;
            return int'(r.layer);          // SCR1..SCR3 on banks 1..3
        end
        return 0;                          // Every other game
    endfunction

    task automatic push_expected(input gfx_req_t r, input logic [SUB_W-1:0] sub);
        int          bank;
        logic [3:0]  off;
        logic [3:0]  msk;
        logic [TILE_W-1:0] tile;
        bank = table_bank(game, r);
        off  = (bank < 0) ? 4'h0 : m_offset[bank*4 +: 4];
        msk  = (bank < 0) ? 4'hF : m_mask[bank*4 +: 4];
        tile = '0;
        tile[15:0] = {(r.code[15:12] & msk) | off, r.code[11:0]};
        exp_addr_q.push_back({tile, sub});
        exp_unm_q.push_back(bank < 0);
        bank_hits[(bank < 0) ? 4 : bank]++;
        if (game == GAME_SF2 && r.layer == OBJ) obj_split[bank]++;
    endtask

    // One clock of stimulus
    task automatic drive_cycle(input logic v, input gfx_req_t r, input logic [SUB_W-1:0] s,
                               input logic w, input logic sel, input logic [15:0] d);
        @(posedge clk);
        #1;
        req_valid = v;
        req       = r;
        req_sub   = s;
        cfg_wr    = w;
        cfg_sel   = sel;
        cfg_data  = d;
        if (v) push_expected(r, s);
        // Model takes this cycle's write after the request
        if (w && sel) m_mask = d;
        else if (w) m_offset = d;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, '0, 1'b0, 1'b0, 16'h0000);
    endtask

    task automatic set_game(input game_e g);
        @(posedge clk);
        #1 game = g;                       // Changed only while the pipeline is empty
    endtask

    function automatic gfx_req_t random_req();
        gfx_req_t r;
        r.layer = layer_e'($urandom_range(4, 0));
        r.code  = 16'($urandom);
        return r;
    endfunction

    // Waits a bounded time for outstanding results
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_addr_q.size() != 0 && n < 8) begin
            @(posedge clk);
            n++;
        end
        if (exp_addr_q.size() != 0) begin
            $display("At %0t ns, %0d request(s) got no result", $time, exp_addr_q.size());
            test_errors++;
            exp_addr_q.delete();
            exp_unm_q.delete();
        end
    endtask

    task automatic require_seen(input int count, input string what);
        if (count == 0) begin
            $display("No request in this test reached %s", what);
            test_errors++;
        end
    endtask

    task automatic start_test();
        test_checks = 0;
        test_errors = 0;
        bank_hits   = '{default: 0};
        obj_split   = '{default: 0};
    endtask

    task automatic end_test(input string name);
        $display("Test %-14s %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        n_tests++;
    endtask

    task automatic run_random(input game_e g, input int n);
        set_game(g);
        drive_cycle(1'b0, '0, '0, 1'b1, 1'b0, 16'($urandom));  // Offset word
        drive_cycle(1'b0, '0, '0, 1'b1, 1'b1, 16'($urandom));  // Mask word
        for (int i = 0; i < n; i++) begin
            drive_cycle(1'b1, random_req(), SUB_W'($urandom), 1'b0, 1'b0, 16'h0000);
        end
        idle_cycle();
        wait_drain();
    endtask

    // Results leave in request order
    always @(negedge clk) begin
        if (!rst && rom_valid) begin
            if (exp_addr_q.size() == 0) begin
                $display("rom_valid pulsed at %0t ns with no request outstanding", $time);
                test_errors++;
            end else begin
                check_addr(rom_addr, exp_addr_q.pop_front(), "rom_addr");
                check_flag(rom_unmapped, exp_unm_q.pop_front(), "rom_unmapped");
            end
        end
    end

    initial begin
        #((TOTAL_REQ + 100) * CLK_PERIOD);
        $display("Watchdog expired at %0t ns, run did not complete", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        game      = GAME_1941;
        cfg_wr    = 1'b0;
        cfg_sel   = 1'b0;
        cfg_data  = 16'h0000;
        req_valid = 1'b0;
        req       = '0;
        req_sub   = '0;
        total_checks = 0;
        total_errors = 0;
        n_tests      = 0;
        void'($urandom(32'h82a5));
        @(negedge rst);

        start_test();
        check_flag(rom_valid, 1'b0, "rom_valid");
        check_flag(rom_unmapped, 1'b1, "rom_unmapped");
        check_addr(rom_addr, '0, "rom_addr");
        drive_cycle(1'b1, random_req(), SUB_W'($urandom), 1'b0, 1'b0, 16'h0000);
        idle_cycle();
        wait_drain();
        end_test("reset_state");

        start_test();
        run_random(GAME_1941, N_DEFAULT);
        end_test("default_game");

        start_test();
        run_random(GAME_FFIGHT, N_FFIGHT);
        require_seen(bank_hits[0], "bank 0");
        require_seen(bank_hits[1], "bank 1");
        require_seen(bank_hits[4], "the unmapped case");
        end_test("ffight");

        start_test();
        run_random(GAME_SF2, N_SF2);
        for (int b = 0; b < 4; b++) require_seen(bank_hits[b], $sformatf("bank %0d", b));
        require_seen(obj_split[0], "bank 0 from a low sprite code");
        require_seen(obj_split[1], "bank 1 from a high sprite code");
        end_test("sf2");

        // Writes land in the same cycles as the requests
        start_test();
        for (int i = 0; i < N_REWRITE; i++) begin
            drive_cycle(1'b1, random_req(), SUB_W'($urandom),
                        ($urandom_range(2, 0) == 0), 1'($urandom), 16'($urandom));
        end
        idle_cycle();
        wait_drain();
        end_test("reg_rewrite");

        $display("Tests run %0d, checks %0d, errors %0d", n_tests, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+common
common/cps_gfx_pkg.sv
gfx/cps_bank_regs.sv
gfx/gfx_mappers.sv
gfx/gfx_addr_gen.sv
hdl/gfx_rom_path.sv
sim/tb_clkgen.sv
sim/gfx_rom_path_tb.sv
